// File: design/axil_ram_pkg.sv
package axil_ram_pkg;

    localparam int addr_width  = 32;
    localparam int data_width  = 32;
    localparam int strb_width  = data_width / 8;
    localparam int index_width = addr_width - $clog2(strb_width);

    typedef logic [addr_width-1:0]  addr_t;
    typedef logic [data_width-1:0]  data_t;
    typedef logic [strb_width-1:0]  strb_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [2:0]             prot_t;

    // AXI response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } axil_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        resp_e resp;
    } axil_b_t;

    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } axil_ar_t;

    typedef struct packed {
        data_t data;
        resp_e resp;
    } axil_r_t;

    // Requests towards the storage block
    typedef struct packed {
        index_t index;
        data_t  data;
        strb_t  strb;
    } mem_wr_req_t;

    typedef struct packed {
        index_t index;
    } mem_rd_req_t;

    // Word aligned and inside the array
    function automatic logic addr_valid(addr_t addr, int unsigned size);
        logic aligned;
        logic in_range;
        aligned  = (addr[$clog2(strb_width)-1:0] == '0);
        in_range = (addr[addr_width-1:$clog2(strb_width)] < size);
        return aligned && in_range;
    endfunction

endpackage

// File: design/axil_ram_write.sv
module axil_ram_write
    import axil_ram_pkg::*;
#(
    parameter int unsigned SIZE = 1024
) (
    input  logic        seq,
    input  logic        arst_n,
    input  logic        pause,

    input  axil_aw_t    aw,
    input  logic        aw_valid,
    output logic        aw_ready,

    input  axil_w_t     w,
    input  logic        w_valid,
    output logic        w_ready,

    output axil_b_t     b,
    output logic        b_valid,
    input  logic        b_ready,

    output mem_wr_req_t wr_req,
    output logic        wr_valid,
    input  logic        wr_ready
);

    axil_aw_t aw_q;
    logic     aw_full;
    axil_w_t  w_q;
    logic     w_full;
    axil_b_t  b_q;

    logic take_aw;
    logic take_w;
    logic pair_ready;
    logic addr_ok;
    logic done;

    // One slot per channel, refilled once the pair has retired
    assign aw_ready = !aw_full && !pause;
    assign w_ready  = !w_full && !pause;
    assign take_aw  = aw_valid && aw_ready;
    assign take_w   = w_valid && w_ready;

    // Pair only retires when the B register is free
    assign pair_ready = aw_full && w_full && !b_valid;
    assign addr_ok    = addr_valid(aw_q.addr, SIZE);

    assign wr_valid = pair_ready && addr_ok;
    // Decode errors skip the memory
    assign done     = pair_ready && (!addr_ok || wr_ready);

    assign wr_req.index = aw_q.addr[addr_width-1:addr_width-index_width];
    assign wr_req.data  = w_q.data;
    assign wr_req.strb  = w_q.strb;

    assign b = b_q;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            aw_full <= 1'b0;
        end else if (take_aw) begin
            aw_full <= 1'b1;
        end else if (done) begin
            aw_full <= 1'b0;
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            w_full <= 1'b0;
        end else if (take_w) begin
            w_full <= 1'b1;
        end else if (done) begin
            w_full <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (take_aw) begin
            aw_q <= aw;
        end
        if (take_w) begin
            w_q <= w;
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            b_valid <= 1'b0;
        end else if (done) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (done) begin
            b_q.resp <= addr_ok ? resp_okay : resp_decerr;
        end
    end

endmodule

// File: design/axil_ram_read.sv
module axil_ram_read
    import axil_ram_pkg::*;
#(
    parameter int unsigned SIZE = 1024
) (
    input  logic        seq,
    input  logic        arst_n,
    input  logic        pause,

    input  axil_ar_t    ar,
    input  logic        ar_valid,
    output logic        ar_ready,

    output axil_r_t     r,
    output logic        r_valid,
    input  logic        r_ready,

    output mem_rd_req_t rd_req,
    output logic        rd_valid,
    input  logic        rd_ready,
    input  data_t       rd_data,
    input  logic        rd_data_valid
);

    axil_ar_t ar_q;
    logic     ar_full;
    axil_r_t  r_q;
    logic     err_pend;

    logic take_ar;
    logic addr_ok;
    logic r_free;
    logic issue_err;
    logic ar_done;

    assign ar_ready = !ar_full && !pause;
    assign take_ar  = ar_valid && ar_ready;
    assign addr_ok  = addr_valid(ar_q.addr, SIZE);

    // R must be empty by the time the result lands, and nothing else may be headed there
    assign r_free = (!r_valid || r_ready) && !rd_data_valid && !err_pend;

    assign rd_valid  = ar_full && addr_ok && r_free;
    assign issue_err = ar_full && !addr_ok && r_free;
    assign ar_done   = (rd_valid && rd_ready) || issue_err;

    assign rd_req.index = ar_q.addr[addr_width-1:addr_width-index_width];

    assign r = r_q;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            ar_full <= 1'b0;
        end else if (take_ar) begin
            ar_full <= 1'b1;
        end else if (ar_done) begin
            ar_full <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (take_ar) begin
            ar_q <= ar;
        end
    end

    // Error reads take the same one-cycle step as memory reads
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            err_pend <= 1'b0;
        end else begin
            err_pend <= issue_err;
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            r_valid <= 1'b0;
        end else if (rd_data_valid || err_pend) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (rd_data_valid) begin
            r_q.data <= rd_data;
            r_q.resp <= resp_okay;
        end else if (err_pend) begin
            r_q.data <= '0;
            r_q.resp <= resp_decerr;
        end
    end

endmodule

// File: design/axil_ram_store.sv
module axil_ram_store
    import axil_ram_pkg::*;
#(
    parameter int unsigned SIZE = 1024
) (
    input  logic        seq,
    input  logic        arst_n,

    input  mem_wr_req_t wr_req,
    input  logic        wr_valid,
    output logic        wr_ready,

    input  mem_rd_req_t rd_req,
    input  logic        rd_valid,
    output logic        rd_ready,

    output data_t       rd_data,
    output logic        rd_data_valid
);

    localparam int idx_width = $clog2(SIZE);

    data_t mem [SIZE];

    logic                 last_wr;
    logic [idx_width-1:0] wr_idx;
    logic [idx_width-1:0] rd_idx;

    // Upper index bits are zero for any decoded access
    assign wr_idx = wr_req.index[idx_width-1:0];
    assign rd_idx = rd_req.index[idx_width-1:0];

    // Round robin: on contention the side not served last time wins
    assign wr_ready = wr_valid && (!rd_valid || !last_wr);
    assign rd_ready = rd_valid && (!wr_valid || last_wr);

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            last_wr <= 1'b0;
        end else if (wr_ready) begin
            last_wr <= 1'b1;
        end else if (rd_ready) begin
            last_wr <= 1'b0;
        end
    end

    // Byte lane merge
    always_ff @(posedge seq) begin
        if (wr_ready) begin
            for (int i = 0; i < strb_width; i++) begin
                if (wr_req.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_req.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge seq) begin
        if (rd_ready) begin
            rd_data <= mem[rd_idx];
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_ready;
        end
    end

endmodule

// File: design/axil_ram.sv
module axil_ram
    import axil_ram_pkg::*;
#(
    parameter int unsigned SIZE = 1024
) (
    input  logic     seq,
    input  logic     arst_n,
    input  logic     pause,

    input  axil_aw_t aw,
    input  logic     aw_valid,
    output logic     aw_ready,

    input  axil_w_t  w,
    input  logic     w_valid,
    output logic     w_ready,

    output axil_b_t  b,
    output logic     b_valid,
    input  logic     b_ready,

    input  axil_ar_t ar,
    input  logic     ar_valid,
    output logic     ar_ready,

    output axil_r_t  r,
    output logic     r_valid,
    input  logic     r_ready
);

    mem_wr_req_t wr_req;
    logic        wr_valid;
    logic        wr_ready;
    mem_rd_req_t rd_req;
    logic        rd_valid;
    logic        rd_ready;
    data_t       rd_data;
    logic        rd_data_valid;

    axil_ram_write #(
        .SIZE (SIZE)
    ) u_write (
        .seq      (seq),
        .arst_n   (arst_n),
        .pause    (pause),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr_req   (wr_req),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready)
    );

    axil_ram_read #(
        .SIZE (SIZE)
    ) u_read (
        .seq           (seq),
        .arst_n        (arst_n),
        .pause         (pause),
        .ar            (ar),
        .ar_valid      (ar_valid),
        .ar_ready      (ar_ready),
        .r             (r),
        .r_valid       (r_valid),
        .r_ready       (r_ready),
        .rd_req        (rd_req),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    axil_ram_store #(
        .SIZE (SIZE)
    ) u_store (
        .seq           (seq),
        .arst_n        (arst_n),
        .wr_req        (wr_req),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .rd_req        (rd_req),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

endmodule

// File: include/axil_ram_checks.svh
`ifndef AXIL_RAM_CHECKS_SVH
`define AXIL_RAM_CHECKS_SVH

// Responses hold until the master takes them
b_hold: assert property (@(posedge seq) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else fail_stop("B response dropped or changed before b_ready");

r_hold: assert property (@(posedge seq) disable iff (!arst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else fail_stop("R response dropped or changed before r_ready");

reset_quiet: assert property (@(posedge seq) !arst_n |-> !b_valid && !r_valid)
    else fail_stop("A response valid was high during reset");

pause_blocks: assert property (@(posedge seq) disable iff (!arst_n)
    pause |-> !aw_ready && !w_ready && !ar_ready)
    else fail_stop("A ready was high while pause was set");

task automatic read_all(input string name);
    for (int i = 0; i < SIZE; i++) begin
        expect_read(name, i * 4);
    end
endtask

// Address as data, then the whole array back
task automatic fill_and_read_back();
    for (int i = 0; i < SIZE; i++) begin
        expect_write("fill write", i * 4, i * 4, 4'hf);
    end
    read_all("fill read");
endtask

task automatic strobe_merge();
    addr_t addr;
    for (int i = 0; i < n_strobe; i++) begin
        addr = (xorshift() % SIZE) * 4;
        expect_write("strobe write", addr, xorshift(), 4'(xorshift()));
        expect_read("strobe read", addr);
    end
endtask

task automatic decode_errors();
    addr_t addr;
    for (int i = 0; i < n_decode; i++) begin
        if (i % 2 == 0) begin
            // Misaligned but inside the array
            addr = (xorshift() % SIZE) * 4 + 1 + i % 3;
        end else begin
            addr = SIZE * 4 + (xorshift() % 64) * 4;
        end
        expect_write("decerr write", addr, xorshift(), 4'hf);
        expect_read("decerr read", addr);
    end
    read_all("decerr read back");
endtask

task automatic pause_windows();
    logic busy;
    addr_t addr;
    busy = 1'b1;
    fork
        begin
            for (int i = 0; i < n_pause; i++) begin
                addr = (xorshift() % SIZE) * 4;
                expect_write("pause write", addr, xorshift(), 4'(xorshift()));
                expect_read("pause read", addr);
            end
            busy = 1'b0;
        end
        begin
            while (busy) begin
                pause = (xorshift() % 3 == 0);
                step();
            end
            pause = 1'b0;
        end
    join
endtask

// Writer keeps to the lower half and reader to the upper half
task automatic mixed_traffic();
    ready_gaps = 1'b1;
    fork
        for (int i = 0; i < n_mixed; i++) begin
            expect_write("mixed write", (xorshift() % (SIZE / 2)) * 4, xorshift(),
                         4'(xorshift()));
        end
        for (int j = 0; j < n_mixed; j++) begin
            expect_read("mixed read", (SIZE / 2 + xorshift() % (SIZE / 2)) * 4);
        end
    join
    ready_gaps = 1'b0;
    read_all("mixed read back");
endtask

`endif

// File: tests/axil_ram_tb.sv
module axil_ram_tb
    import axil_ram_pkg::*;
();

    localparam int unsigned SIZE = 256;
    localparam int n_strobe = 48;
    localparam int n_decode = 8;
    localparam int n_pause = 16;
    localparam int n_mixed = 48;
    // Writes and reads per phase, plus two extra full read-back passes
    localparam int n_trans = 2 * (SIZE + n_strobe + n_decode + n_pause + n_mixed) + 2 * SIZE;
    localparam int cycle_limit = 40 * n_trans + 200;

    logic        seq;
    logic        arst_n;
    logic        pause;
    axil_aw_t    aw;
    logic        aw_valid;
    logic        aw_ready;
    axil_w_t     w;
    logic        w_valid;
    logic        w_ready;
    axil_b_t     b;
    logic        b_valid;
    logic        b_ready;
    axil_ar_t    ar;
    logic        ar_valid;
    logic        ar_ready;
    axil_r_t     r;
    logic        r_valid;
    logic        r_ready;

    data_t       model [SIZE];
    logic [31:0] rng_state;
    logic        ready_gaps;
    int unsigned cycles;

    axil_ram #(.SIZE(SIZE)) DUT (.*);

    initial begin
        seq = 1'b0;
        forever #50 seq = ~seq;
    end

    always @(posedge seq) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_stop("Timeout, the DUT stopped finishing transactions");
        end
    end

    task automatic fail_stop(input string what);
        $display("TEST FAILED");
        $display("%s", what);
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else
            fail_stop($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Ready stays high unless gaps are on, then drops about a quarter of the time
    function automatic logic ready_now();
        return !ready_gaps || (xorshift() % 4 != 0);
    endfunction

    task automatic step();
        @(posedge seq);
        #10;
    endtask

    // Aligned and inside the array
    function automatic logic decodes(input addr_t addr);
        return (addr[1:0] == 2'b00) && (addr < SIZE * 4);
    endfunction

    task automatic write_word(input addr_t addr, input data_t data, input strb_t strb,
                              output resp_e resp);
        logic aw_done;
        logic w_done;
        logic b_done;
        aw = '{addr: addr, prot: 3'b000};
        w = '{data: data, strb: strb};
        aw_valid = 1'b1;
        w_valid = 1'b1;
        b_done = 1'b0;
        while (aw_valid || w_valid) begin
            @(negedge seq);
            aw_done = aw_ready;
            w_done = w_ready;
            step();
            aw_valid = aw_valid && !aw_done;
            w_valid = w_valid && !w_done;
        end
        while (!b_done) begin
            b_ready = ready_now();
            @(negedge seq);
            b_done = b_valid && b_ready;
            resp = b.resp;
            step();
        end
        b_ready = 1'b0;
    endtask

    task automatic read_word(input addr_t addr, output axil_r_t resp);
        logic ar_done;
        logic r_done;
        ar = '{addr: addr, prot: 3'b000};
        ar_valid = 1'b1;
        r_done = 1'b0;
        while (ar_valid) begin
            @(negedge seq);
            ar_done = ar_ready;
            step();
            ar_valid = !ar_done;
        end
        while (!r_done) begin
            r_ready = ready_now();
            @(negedge seq);
            r_done = r_valid && r_ready;
            resp = r;
            step();
        end
        r_ready = 1'b0;
    endtask

    task automatic expect_write(input string name, input addr_t addr, input data_t data,
                                input strb_t strb);
        resp_e resp;
        write_word(addr, data, strb, resp);
        if (decodes(addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    model[addr >> 2][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
        check_eq(name, decodes(addr) ? resp_okay : resp_decerr, resp);
    endtask

    task automatic expect_read(input string name, input addr_t addr);
        axil_r_t got;
        read_word(addr, got);
        check_eq({name, " resp"}, decodes(addr) ? resp_okay : resp_decerr, got.resp);
        check_eq({name, " data"}, decodes(addr) ? model[addr >> 2] : '0, got.data);
    endtask

    initial begin
        arst_n = 1'b0;
        pause = 1'b0;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        rng_state = 32'h7e84;
        ready_gaps = 1'b0;
        repeat (10) @(posedge seq);
        #10;
        arst_n = 1'b1;
        @(negedge seq);
        assert (aw_ready && w_ready && ar_ready && !b_valid && !r_valid) else
            fail_stop("Ready or valid outputs wrong on the first cycle after reset");
        step();
        fill_and_read_back();
        strobe_merge();
        decode_errors();
        pause_windows();
        mixed_traffic();
        $display("TEST OK");
        $finish;
    end

    `include "axil_ram_checks.svh"

endmodule

// File: list.f
+incdir+include
design/axil_ram_pkg.sv
design/axil_ram_write.sv
design/axil_ram_read.sv
design/axil_ram_store.sv
design/axil_ram.sv
tests/axil_ram_tb.sv
